/* include/kbd_macros.svh */
`ifndef KBD_MACROS_SVH
`define KBD_MACROS_SVH

// receive FIFO entries between PS/2 receiver and key matrix
`define KBD_FIFO_DEPTH 4

// BBC matrix columns, numbered 0 to 9
`define KBD_COLUMNS 10

// stable samples before a PS/2 clock level is believed
`define KBD_PS2_FILTER 4

`endif

/* src/kbdPkg.sv */
package kbdPkg;

	// one byte as received from the keyboard
	typedef struct packed {
		logic [7:0] code;
	} scanEntryT;

	// one valid/ready stream beat
	typedef struct packed {
		logic      valid;    // producer side
		scanEntryT payload;  // producer side, stable while valid and not ready
		// upstream-driven group
		// ready flows back from the consumer to the producer
		logic      ready;
	} scanStreamT;

	// host matrix select as presented by the BBC scan logic
	typedef struct packed {
		logic [3:0] column;
		logic [2:0] row;
	} matrixSelT;

	// position of a key in the BBC matrix
	typedef struct packed {
		logic       mapped;  // low for codes with no BBC key
		logic [2:0] row;
		logic [3:0] column;
	} bbcKeyT;

endpackage

/* src/ps2Receiver.sv */
`timescale 1ns/1ns
`include "kbd_macros.svh"

module ps2Receiver (
	input  logic               CLK_hPROC,
	input  logic               nRESET,
	input  logic               ps2Clk,
	input  logic               ps2Data,
	output kbdPkg::scanStreamT out,
	input  logic               outReady,
	output logic               frameError
);
	import kbdPkg::*;

	localparam int filterLen = `KBD_PS2_FILTER;
	localparam logic [3:0] stopBit = 4'd10;

	logic [1:0] clkSync;            // two-flop synchroniser
	logic [1:0] dataSync;
	logic [filterLen-1:0] clkHist;  // recent synced clock samples
	logic clkFilt;                  // debounced PS/2 clock
	logic fallEdge;
	logic [3:0] bitCount;           // bits taken in this frame
	logic [9:0] frameBits;          // parity, data, start
	logic frameDone;
	logic frameGood;
	logic byteHeld;
	logic capture;
	logic heldValid;
	scanEntryT heldByte;

	// a fall is seen once the history has settled low
	assign fallEdge = clkFilt && (clkHist == '0);
	assign frameDone = fallEdge && (bitCount == stopBit);

	// start low, stop high, odd parity over data and parity bit
	assign frameGood = !frameBits[0] && dataSync[1] && (^frameBits[9:1]);

	assign byteHeld = heldValid && !outReady;  // previous byte not yet taken
	assign capture = frameDone && frameGood && !byteHeld;

	assign out = '{valid: heldValid, payload: heldByte, ready: outReady};

	always_ff @(posedge CLK_hPROC) begin
		if (nRESET) begin
			clkSync <= 2'b11;  // lines idle high
			dataSync <= 2'b11;
			clkHist <= '1;
			clkFilt <= 1'b1;
		end else begin
			clkSync <= {clkSync[0], ps2Clk};
			dataSync <= {dataSync[0], ps2Data};
			clkHist <= {clkHist[filterLen-2:0], clkSync[1]};
			if (clkHist == '1)
				clkFilt <= 1'b1;
			else if (clkHist == '0)
				clkFilt <= 1'b0;
		end
	end

	always_ff @(posedge CLK_hPROC) begin
		if (nRESET) begin
			bitCount <= '0;
			heldValid <= 1'b0;
			frameError <= 1'b0;
		end else begin
			frameError <= 1'b0;
			if (heldValid && outReady)
				heldValid <= 1'b0;
			if (fallEdge) begin
				if (bitCount == stopBit)
					bitCount <= '0;
				else
					bitCount <= bitCount + 4'd1;
			end
			if (capture)
				heldValid <= 1'b1;  // visible the cycle after the stop bit
			else if (frameDone)
				frameError <= 1'b1;  // bad framing, or byte still held
		end
	end

	// shift register and held byte
	always_ff @(posedge CLK_hPROC) begin
		if (fallEdge && (bitCount != stopBit))
			frameBits <= {dataSync[1], frameBits[9:1]};  // LSB first
		if (capture)
			heldByte.code <= frameBits[8:1];
	end

endmodule

/* src/scanFifo.sv */
`timescale 1ns/1ns

module scanFifo #(
	parameter type payloadT = logic [7:0],
	parameter int  depth    = 2
) (
	input  logic    CLK_hPROC,
	input  logic    nRESET,
	input  logic    inValid,
	input  payloadT inData,
	output logic    inReady,
	output logic    outValid,
	output payloadT outData,
	input  logic    outReady
);
	localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
	localparam int countWidth = $clog2(depth + 1);

	payloadT mem [depth];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [countWidth-1:0] fill;  // entries held
	logic push;
	logic pop;

	// pointers wrap at depth, which need not be a power of two
	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		return (ptr == ptrWidth'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign inReady = (fill != countWidth'(depth));
	assign outValid = (fill != '0);
	assign outData = mem[rdPtr];  // head of queue
	assign push = inValid && inReady;
	assign pop = outValid && outReady;

	always_ff @(posedge CLK_hPROC) begin
		if (nRESET) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fill <= '0;
		end else begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({push, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;  // idle, or push and pop together
			endcase
		end
	end

	always_ff @(posedge CLK_hPROC) begin
		if (push)
			mem[wrPtr] <= inData;
	end

endmodule

/* src/bbcKeyMatrix.sv */
`timescale 1ns/1ns
`include "kbd_macros.svh"

module bbcKeyMatrix (
	input  logic              CLK_hPROC,
	input  logic              nRESET,
	input  logic              inValid,
	input  kbdPkg::scanEntryT inData,
	output logic              inReady,
	input  logic              autoscan,
	input  kbdPkg::matrixSelT matrixSel,
	output logic              columnMatch,
	output logic              rowMatch
);
	import kbdPkg::*;

	localparam int columns = `KBD_COLUMNS;
	localparam logic [7:0] releaseCode = 8'hF0;
	localparam logic [7:0] extendCode = 8'hE0;

	scanEntryT codeReg;     // byte taken from the FIFO
	logic codeValid;
	bbcKeyT updKey;         // registered translation
	logic updValid;
	logic updRelease;
	logic releasePending;   // F0 seen, next key is a break
	logic [7:0] keyState [columns];
	logic [3:0] scanColumn; // autoscan counter
	logic [3:0] activeColumn;
	logic [7:0] activeRows;

	// PC set 2 code to BBC {row, column}
	function automatic bbcKeyT translate(input logic [7:0] code);
		logic [6:0] rc;
		logic hit;
		hit = 1'b1;
		rc = '0;
		case (code)
			8'h76: rc = {3'd7, 4'd0};  // escape
			8'h16: rc = {3'd3, 4'd0};
			8'h1E: rc = {3'd3, 4'd1};
			8'h26: rc = {3'd1, 4'd1};
			8'h25: rc = {3'd1, 4'd2};
			8'h2E: rc = {3'd1, 4'd3};
			8'h36: rc = {3'd3, 4'd4};
			8'h3D: rc = {3'd2, 4'd4};
			8'h3E: rc = {3'd1, 4'd5};
			8'h46: rc = {3'd2, 4'd6};
			8'h45: rc = {3'd2, 4'd7};
			8'h4E: rc = {3'd1, 4'd7};  // minus and equals
			8'h66: rc = {3'd5, 4'd9};  // backspace as delete
			8'h0D: rc = {3'd6, 4'd0};  // tab
			8'h15: rc = {3'd1, 4'd0};
			8'h1D: rc = {3'd2, 4'd1};
			8'h24: rc = {3'd2, 4'd2};
			8'h2D: rc = {3'd3, 4'd3};
			8'h2C: rc = {3'd2, 4'd3};
			8'h35: rc = {3'd4, 4'd4};
			8'h3C: rc = {3'd3, 4'd5};
			8'h43: rc = {3'd2, 4'd5};
			8'h44: rc = {3'd3, 4'd6};
			8'h4D: rc = {3'd3, 4'd7};
			8'h54: rc = {3'd3, 4'd8};  // open bracket
			8'h5B: rc = {3'd5, 4'd8};  // close bracket
			8'h5A: rc = {3'd4, 4'd9};  // return
			8'h14: rc = {3'd0, 4'd1};  // left ctrl
			8'h1C: rc = {3'd4, 4'd1};
			8'h1B: rc = {3'd5, 4'd1};
			8'h23: rc = {3'd3, 4'd2};
			8'h2B: rc = {3'd4, 4'd3};
			8'h34: rc = {3'd5, 4'd3};
			8'h33: rc = {3'd5, 4'd4};
			8'h3B: rc = {3'd4, 4'd5};
			8'h42: rc = {3'd4, 4'd6};
			8'h4B: rc = {3'd5, 4'd6};
			8'h4C: rc = {3'd5, 4'd7};  // semicolon
			8'h52: rc = {3'd2, 4'd8};  // quote as underscore
			8'h0E: rc = {3'd1, 4'd8};  // backtick as caret
			8'h12,
			8'h59: rc = {3'd0, 4'd0};  // either shift
			8'h61: rc = {3'd7, 4'd8};  // UK backslash
			8'h1A: rc = {3'd6, 4'd1};
			8'h22: rc = {3'd4, 4'd2};
			8'h21: rc = {3'd5, 4'd2};
			8'h2A: rc = {3'd6, 4'd3};
			8'h32: rc = {3'd6, 4'd4};
			8'h31: rc = {3'd5, 4'd5};
			8'h3A: rc = {3'd6, 4'd5};
			8'h41: rc = {3'd6, 4'd6};  // comma
			8'h49: rc = {3'd6, 4'd7};  // full stop
			8'h4A: rc = {3'd6, 4'd8};  // slash
			8'h11: rc = {3'd5, 4'd0};  // left alt as shift lock
			8'h29: rc = {3'd6, 4'd2};  // space
			8'h58: rc = {3'd4, 4'd0};  // caps lock
			8'h05: rc = {3'd7, 4'd1};  // function keys f1 up
			8'h06: rc = {3'd7, 4'd2};
			8'h04: rc = {3'd7, 4'd3};
			8'h0C: rc = {3'd1, 4'd4};
			8'h03: rc = {3'd7, 4'd4};
			8'h0B: rc = {3'd7, 4'd5};
			8'h83: rc = {3'd1, 4'd6};
			8'h0A: rc = {3'd7, 4'd6};
			8'h01: rc = {3'd7, 4'd7};
			8'h09: rc = {3'd2, 4'd0};  // f10 as f0
			8'h75: rc = {3'd3, 4'd9};  // cursor up
			8'h6B: rc = {3'd1, 4'd9};  // cursor left
			8'h74: rc = {3'd7, 4'd9};  // cursor right
			8'h72: rc = {3'd2, 4'd9};  // cursor down
			8'h55: rc = {3'd4, 4'd8};  // equals as colon
			8'h78: rc = {3'd4, 4'd7};  // f11 as at sign
			8'h07: rc = {3'd6, 4'd9};  // f12 as copy
			default: hit = 1'b0;
		endcase
		return '{mapped: hit, row: rc[6:4], column: rc[3:0]};
	endfunction

	assign inReady = !codeValid;  // one idle cycle after each accept

	always_ff @(posedge CLK_hPROC) begin
		if (nRESET) begin
			codeValid <= 1'b0;
			updValid <= 1'b0;
			releasePending <= 1'b0;
			scanColumn <= '0;
		end else begin
			codeValid <= inValid && inReady;
			updValid <= 1'b0;
			if (codeValid) begin
				if (codeReg.code == releaseCode) begin
					releasePending <= 1'b1;
				end else if (codeReg.code != extendCode) begin
					updValid <= 1'b1;  // unmapped codes just clear the flag
					releasePending <= 1'b0;
				end
			end
			if (scanColumn == 4'(columns - 1))
				scanColumn <= '0;
			else
				scanColumn <= scanColumn + 4'd1;
		end
	end

	always_ff @(posedge CLK_hPROC) begin
		if (inValid && inReady)
			codeReg <= inData;
		if (codeValid) begin
			updKey <= translate(codeReg.code);
			updRelease <= releasePending;
		end
	end

	always_ff @(posedge CLK_hPROC) begin
		if (nRESET) begin
			for (int c = 0; c < columns; c++) begin
				keyState[c] <= '0;
			end
		end else if (updValid && updKey.mapped && (updKey.column < columns)) begin
			keyState[updKey.column][updKey.row] <= !updRelease;
		end
	end

	assign activeColumn = autoscan ? scanColumn : matrixSel.column;
	assign activeRows = (activeColumn < columns) ? keyState[activeColumn] : '0;
	assign columnMatch = |activeRows[7:1];  // row 0 holds shift and ctrl
	assign rowMatch = !autoscan && activeRows[matrixSel.row];

endmodule

/* src/bbcKeyboard.sv */
`timescale 1ns/1ns
`include "kbd_macros.svh"

module bbcKeyboard (
	input  logic              CLK_hPROC,
	input  logic              nRESET,
	input  logic              autoscan,
	input  kbdPkg::matrixSelT matrixSel,
	input  logic              ps2Clk,
	input  logic              ps2Data,
	output logic              columnMatch,
	output logic              rowMatch,
	output logic              frameError
);
	import kbdPkg::*;

	scanStreamT rxStream;   // receiver to FIFO
	scanStreamT keyStream;  // FIFO to key matrix
	logic fifoInReady;
	logic fifoOutValid;
	scanEntryT fifoOutData;
	logic matrixReady;

	assign keyStream = '{valid: fifoOutValid, payload: fifoOutData, ready: matrixReady};

	ps2Receiver receiver (
		.CLK_hPROC (CLK_hPROC),
		.nRESET    (nRESET),
		.ps2Clk    (ps2Clk),
		.ps2Data   (ps2Data),
		.out       (rxStream),
		.outReady  (fifoInReady),
		.frameError(frameError)
	);

	// absorbs bursts while the matrix takes one byte every two cycles
	scanFifo #(
		.payloadT(kbdPkg::scanEntryT),
		.depth   (`KBD_FIFO_DEPTH)
	) fifo (
		.CLK_hPROC(CLK_hPROC),
		.nRESET   (nRESET),
		.inValid  (rxStream.valid),
		.inData   (rxStream.payload),
		.inReady  (fifoInReady),
		.outValid (fifoOutValid),
		.outData  (fifoOutData),
		.outReady (keyStream.ready)
	);

	bbcKeyMatrix matrix (
		.CLK_hPROC  (CLK_hPROC),
		.nRESET     (nRESET),
		.inValid    (keyStream.valid),
		.inData     (keyStream.payload),
		.inReady    (matrixReady),
		.autoscan   (autoscan),
		.matrixSel  (matrixSel),
		.columnMatch(columnMatch),
		.rowMatch   (rowMatch)
	);

endmodule

/* testbench/bbcKeyboard_assert.sv */
`timescale 1ns/1ns

module bbcKeyboard_assert (
	input logic       CLK_hPROC,
	input logic       nRESET,
	input logic       valid,
	input logic       ready,
	input logic [7:0] payload,
	input logic       empty,
	input logic       presenting,
	input logic       autoscan,
	input logic       rowMatch
);

	// an offered beat stays put until it is taken
	assert property (@(posedge CLK_hPROC) disable iff (nRESET)
		valid && !ready |=> valid && $stable(payload))
		else $error("stream beat dropped or changed before it was taken");

	assert property (@(posedge CLK_hPROC) disable iff (nRESET) empty |-> !presenting)
		else $error("FIFO presents data while empty");

	assert property (@(posedge CLK_hPROC) disable iff (nRESET) autoscan |-> !rowMatch)
		else $error("rowMatch high during autoscan");

endmodule

// receiver to FIFO stream, and FIFO occupancy from the pointers
bind scanFifo bbcKeyboard_assert fifoChecks (
	.CLK_hPROC (CLK_hPROC),
	.nRESET    (nRESET),
	.valid     (inValid),
	.ready     (inReady),
	.payload   (inData),
	.empty     ((wrPtr == rdPtr) && inReady),
	.presenting(outValid),
	.autoscan  (1'b0),
	.rowMatch  (1'b0)
);

// FIFO to matrix stream, and the match outputs
bind bbcKeyMatrix bbcKeyboard_assert matrixChecks (
	.CLK_hPROC (CLK_hPROC),
	.nRESET    (nRESET),
	.valid     (inValid),
	.ready     (inReady),
	.payload   (inData),
	.empty     (1'b0),
	.presenting(inValid),
	.autoscan  (autoscan),
	.rowMatch  (rowMatch)
);

/* testbench/tbBbcKeyboard.sv */
`timescale 1ns/1ns
`include "kbd_macros.svh"

module tbBbcKeyboard;
	import kbdPkg::*;

	localparam logic [31:0] lfsrSeed = 32'h49ce_02b1;
	localparam logic [31:0] lfsrMask = 32'h8020_0003;
	localparam int halfBit = 8;      // system clocks per PS/2 half period
	localparam int waitLimit = 400;  // cycles
	localparam logic [7:0] keyList [16] = '{8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36,
		8'h1C, 8'h1B, 8'h23, 8'h2D, 8'h15, 8'h4B, 8'h4D, 8'h5A, 8'h29, 8'h54};
	localparam logic [7:0] burstCodes [8] = '{8'h2D, 8'h15, 8'hF0, 8'h2D,
		8'h4B, 8'hF0, 8'h15, 8'h15};

	logic CLK_hPROC;
	logic nRESET;
	logic autoscan;
	matrixSelT matrixSel;
	logic ps2Clk;
	logic ps2Data;
	logic columnMatch;
	logic rowMatch;
	logic frameError;

	logic [7:0] modelKeys [`KBD_COLUMNS];  // expected key state, one byte per column
	logic modelRelease;
	logic [31:0] lfsrState;
	logic compareOn;
	logic recordOn;
	logic [7:0] seenCodes [$];  // bytes taken by the matrix
	logic autoHits [20];
	int checks, errors, testsRun, testsPassed, testErrors;
	int pulses, pulseMark, firstHit, hitCount;

	bbcKeyboard UUT (
		.CLK_hPROC  (CLK_hPROC),
		.nRESET     (nRESET),
		.autoscan   (autoscan),
		.matrixSel  (matrixSel),
		.ps2Clk     (ps2Clk),
		.ps2Data    (ps2Data),
		.columnMatch(columnMatch),
		.rowMatch   (rowMatch),
		.frameError (frameError)
	);

	always #50 CLK_hPROC = ~CLK_hPROC;

	// subset of the BBC table as {mapped, row, column}
	function automatic logic [7:0] refTranslate(input logic [7:0] code);
		case (code)
			8'h16: return {1'b1, 3'd3, 4'd0};
			8'h1E: return {1'b1, 3'd3, 4'd1};
			8'h26: return {1'b1, 3'd1, 4'd1};
			8'h25: return {1'b1, 3'd1, 4'd2};
			8'h2E: return {1'b1, 3'd1, 4'd3};
			8'h36: return {1'b1, 3'd3, 4'd4};
			8'h1C: return {1'b1, 3'd4, 4'd1};
			8'h1B: return {1'b1, 3'd5, 4'd1};
			8'h23: return {1'b1, 3'd3, 4'd2};
			8'h2D: return {1'b1, 3'd3, 4'd3};
			8'h15: return {1'b1, 3'd1, 4'd0};
			8'h4B: return {1'b1, 3'd5, 4'd6};
			8'h4C: return {1'b1, 3'd5, 4'd7};  // semicolon
			8'h4D: return {1'b1, 3'd3, 4'd7};
			8'h5A: return {1'b1, 3'd4, 4'd9};
			8'h29: return {1'b1, 3'd6, 4'd2};
			8'h54: return {1'b1, 3'd3, 4'd8};
			8'h12: return {1'b1, 3'd0, 4'd0};  // shift
			default: return 8'h00;
		endcase
	endfunction

	// expected {columnMatch, rowMatch} in manual mode
	function automatic logic [1:0] refMatch(input matrixSelT sel);
		logic [7:0] rows;
		rows = (sel.column < `KBD_COLUMNS) ? modelKeys[sel.column] : 8'h00;
		return {|rows[7:1], rows[sel.row]};  // row 0 never drives the column line
	endfunction

	function automatic void modelByte(input logic [7:0] code);
		logic [7:0] key;
		key = refTranslate(code);
		if (code == 8'hF0) begin
			modelRelease = 1'b1;
		end else if (code != 8'hE0) begin
			if (key[7])
				modelKeys[key[3:0]][key[6:4]] = !modelRelease;
			modelRelease = 1'b0;
		end
	endfunction

	function automatic logic [7:0] randBits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[6:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ lfsrMask) : (lfsrState >> 1);
		end
		return r;
	endfunction

	function automatic logic pipelineBusy();
		return UUT.receiver.heldValid || UUT.fifo.outValid || UUT.matrix.codeValid
			|| UUT.matrix.updValid;
	endfunction

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] want,
		input string what);
		checks++;
		if (actual !== want) begin
			errors++;
			$display("ERROR %0t ns: %s is %0h, expected %0h", $time, what, actual, want);
		end
	endtask

	task automatic applyReset();
		@(negedge CLK_hPROC);
		nRESET = 1'b1;
		repeat (10) @(negedge CLK_hPROC);
		nRESET = 1'b0;
		for (int c = 0; c < `KBD_COLUMNS; c++)
			modelKeys[c] = 8'h00;
		modelRelease = 1'b0;
	endtask

	// start, 8 data bits LSB first, odd parity, stop
	task automatic sendFrame(input logic [7:0] code, input logic badParity);
		logic [10:0] bits;
		bits = {1'b1, (~^code) ^ badParity, code, 1'b0};
		@(negedge CLK_hPROC);
		for (int i = 0; i < 11; i++) begin
			ps2Data = bits[i];
			repeat (halfBit) @(negedge CLK_hPROC);
			ps2Clk = 1'b0;
			repeat (halfBit) @(negedge CLK_hPROC);
			ps2Clk = 1'b1;
		end
	endtask

	task automatic sendByte(input logic [7:0] code);
		sendFrame(code, 1'b0);
		modelByte(code);
	endtask

	task automatic sendKey(input logic [7:0] code, input logic isBreak);
		if (isBreak)
			sendByte(8'hF0);
		sendByte(code);
	endtask

	task automatic waitIdle();
		int n;
		n = 0;
		while (pipelineBusy() && n < waitLimit) begin
			@(negedge CLK_hPROC);
			n++;
		end
		if (pipelineBusy()) begin
			errors++;
			$display("timeout: key pipeline still busy after %0d cycles", waitLimit);
		end
	endtask

	task automatic waitMatch(input int col, input int row, input string what);
		logic [1:0] want;
		int n;
		@(negedge CLK_hPROC);
		matrixSel.column = 4'(col);
		matrixSel.row = 3'(row);
		want = refMatch(matrixSel);
		n = 0;
		do begin
			@(negedge CLK_hPROC);
			n++;
		end while ({columnMatch, rowMatch} !== want && n < waitLimit);
		if ({columnMatch, rowMatch} !== want)
			$display("timeout: match lines never settled for %s", what);
		checkValue({columnMatch, rowMatch}, want, what);
	endtask

	// the compare process checks every selected position
	task automatic sweep(input int firstCol, input int lastCol);
		@(negedge CLK_hPROC);
		compareOn = 1'b1;
		for (int c = firstCol; c <= lastCol; c++) begin
			for (int r = 0; r < 8; r++) begin
				matrixSel.column = 4'(c);
				matrixSel.row = 3'(r);
				@(negedge CLK_hPROC);
			end
		end
		compareOn = 1'b0;
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (errors == testErrors) begin
			testsPassed++;
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - testErrors);
		end
		testErrors = errors;
	endtask

	always @(posedge CLK_hPROC) begin
		if (compareOn && !nRESET && !autoscan)
			checkValue({columnMatch, rowMatch}, refMatch(matrixSel),
				$sformatf("match lines at column %0d row %0d", matrixSel.column, matrixSel.row));
	end

	always @(negedge CLK_hPROC) begin
		if (frameError)
			pulses++;
		if (recordOn && UUT.matrix.inValid && UUT.matrix.inReady)
			seenCodes.push_back(UUT.matrix.inData.code);
	end

	initial begin
		CLK_hPROC = 1'b0;
		nRESET = 1'b1;
		autoscan = 1'b0;
		matrixSel = '0;
		ps2Clk = 1'b1;  // PS/2 lines idle high
		ps2Data = 1'b1;
		lfsrState = lfsrSeed;
		{compareOn, recordOn} = 2'b00;
		{checks, errors, testsRun, testsPassed, testErrors, pulses} = '0;
		applyReset();
		@(negedge CLK_hPROC);
		checkValue({columnMatch, rowMatch, frameError}, 3'b000, "outputs after reset");

		sendKey(8'h1C, 1'b0);  // A at column 1 row 4
		waitMatch(1, 4, "A pressed");
		sendKey(8'h1C, 1'b1);
		waitMatch(1, 4, "A released");
		sendKey(8'h12, 1'b0);
		waitMatch(0, 0, "shift pressed");
		sendKey(8'h12, 1'b1);
		waitMatch(0, 0, "shift released");
		sendKey(8'h4C, 1'b0);
		waitMatch(7, 5, "semicolon pressed");
		sendKey(8'h4C, 1'b1);
		waitMatch(7, 5, "semicolon released");
		endTest("press and release");

		for (int i = 0; i < 10; i++)
			sendKey(keyList[randBits(4)], 1'b0);
		waitIdle();
		sweep(0, `KBD_COLUMNS - 1);
		endTest("random keys");

		pulseMark = pulses;
		sendByte(8'h7E);  // scroll lock has no BBC key
		sendByte(8'hE0);
		sendByte(8'h1F);
		waitIdle();
		checkValue(pulses - pulseMark, 0, "frameError pulses for good frames");
		sendFrame(8'h29, 1'b1);
		waitIdle();
		checkValue(pulses - pulseMark, 1, "frameError pulses for a parity error");
		sweep(0, `KBD_COLUMNS - 1);
		endTest("ignored input");

		seenCodes.delete();
		recordOn = 1'b1;
		for (int i = 0; i < 8; i++)
			sendByte(burstCodes[i]);
		waitIdle();
		recordOn = 1'b0;
		checkValue(seenCodes.size(), 8, "bytes taken by the key matrix");
		for (int i = 0; i < 8 && i < seenCodes.size(); i++)
			checkValue(seenCodes[i], burstCodes[i], $sformatf("burst byte %0d", i));
		sweep(0, `KBD_COLUMNS - 1);
		endTest("burst");

		applyReset();
		sendKey(8'h4D, 1'b0);  // the only key held, column 7
		waitIdle();
		@(negedge CLK_hPROC);
		autoscan = 1'b1;
		for (int i = 0; i < 20; i++) begin
			@(negedge CLK_hPROC);
			autoHits[i] = columnMatch;
			checkValue(rowMatch, 0, "rowMatch in autoscan");
		end
		@(negedge CLK_hPROC);
		autoscan = 1'b0;
		hitCount = 0;
		firstHit = -1;
		for (int i = 0; i < 20; i++) begin
			if (autoHits[i]) begin
				if (hitCount == 1)
					checkValue(i - firstHit, 10, "autoscan period");
				if (hitCount == 0)
					firstHit = i;
				hitCount++;
			end
		end
		checkValue(hitCount, 2, "columnMatch highs in twenty cycles");
		endTest("autoscan");

		waitMatch(7, 3, "held key in manual mode");
		sweep(10, 15);
		endTest("out-of-range column");

		$display("%0d of %0d tests passed, %0d checks, %0d errors",
			testsPassed, testsRun, checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* flist.f */
+incdir+include
src/kbdPkg.sv
src/ps2Receiver.sv
src/scanFifo.sv
src/bbcKeyMatrix.sv
src/bbcKeyboard.sv
testbench/bbcKeyboard_assert.sv
testbench/tbBbcKeyboard.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then judge the log
verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tbBbcKeyboard -o tbBbcKeyboard \
	&& ./obj_dir/tbBbcKeyboard > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
